//--- rob_issue.sv
// Reorder buffer issue side
module rob_issue import rob_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              req_valid_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    output logic              req_ready_o,
    output logic              mem_req_valid_o,
    output logic [TAG_W-1:0]  mem_req_tag_o,
    output logic [ADDR_W-1:0] mem_req_addr_o,
    input  logic              tag_ret_valid_i,
    input  logic [TAG_W-1:0]  tag_ret_i,
    output logic              busy_o
);

    logic             free_valid;
    logic [TAG_W-1:0] free_tag;
    logic             ret_ready;
    logic             issue;
    logic             ret;
    // Issued minus returned, 0 to ROB_DEPTH
    logic [TAG_W:0]   outstanding_q;
    // Tag the next issue must carry
    logic [TAG_W-1:0] expect_tag_q;

    tag_queue i_tag_queue (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .tag_i   (tag_ret_i),
        .valid_i (tag_ret_valid_i),
        .ready_o (ret_ready),
        .tag_o   (free_tag),
        .valid_o (free_valid),
        .ready_i (issue)
    );

    // Requests wait only for a free tag
    assign req_ready_o = free_valid;
    assign issue       = req_valid_i && free_valid;
    assign ret         = tag_ret_valid_i && ret_ready;
    assign busy_o      = (outstanding_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            mem_req_valid_o <= 1'b0;
            outstanding_q   <= '0;
            expect_tag_q    <= '0;
        end else begin
            // One-cycle strobe per accepted request
            mem_req_valid_o <= issue;
            outstanding_q   <= outstanding_q + {{TAG_W{1'b0}}, issue}
                                             - {{TAG_W{1'b0}}, ret};
            if (issue) begin
                expect_tag_q <= tag_next(expect_tag_q);
            end
        end
    end

    // Memory request payload
    always_ff @(posedge clk_i) begin
        if (issue) begin
            mem_req_tag_o  <= free_tag;
            mem_req_addr_o <= req_addr_i;
        end
    end

    // Flush is only defined with nothing in flight
    assert property (@(posedge clk_i) disable iff (!rst_n_i) flush_i |-> !busy_o)
        else $error("rob_issue: flush while busy");

    // Tags go out in sequence, which lets retire use a plain counter
    assert property (@(posedge clk_i) disable iff (!rst_n_i) issue |-> free_tag == expect_tag_q)
        else $error("rob_issue: tag %0d out of sequence", free_tag);

endmodule

//--- rob_pkg.sv
// Reorder buffer shared definitions
package rob_pkg;

    // Tags and buffer entries
    localparam int unsigned ROB_DEPTH = 8;
    localparam int unsigned TAG_W     = $clog2(ROB_DEPTH);

    // Memory port widths
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned DATA_W = 32;

    // Free-tag FIFO takes a push while full if a pop happens the same cycle
    localparam bit SAME_CYCLE_RW = 1'b1;

    // Following tag in issue order, wraps after the last entry
    function automatic logic [TAG_W-1:0] tag_next(input logic [TAG_W-1:0] tag);
        if (tag == TAG_W'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return tag + 1'b1;
    endfunction

    // Memory data word: address on top, inverted address below
    function automatic logic [DATA_W-1:0] mem_data(input logic [ADDR_W-1:0] addr);
        return {addr, ~addr};
    endfunction

endpackage

//--- rob_retire.sv
// Reorder buffer in-order retire
module rob_retire import rob_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              head_valid_i,
    input  logic [DATA_W-1:0] head_data_i,
    input  logic              out_ready_i,
    output logic              out_valid_o,
    output logic [DATA_W-1:0] out_data_o,
    output logic [TAG_W-1:0]  head_tag_o,
    output logic              retire_o,
    output logic              tag_ret_valid_o,
    output logic [TAG_W-1:0]  tag_ret_o
);

    // Oldest outstanding tag
    logic [TAG_W-1:0] head_q;
    logic             fire;

    // Head entry is presented as soon as its response lands
    assign out_valid_o = head_valid_i;
    assign out_data_o  = head_data_i;
    assign fire        = head_valid_i && out_ready_i;

    assign head_tag_o = head_q;

    // Transfer clears the entry and frees its tag
    assign retire_o        = fire;
    assign tag_ret_valid_o = fire;
    assign tag_ret_o       = head_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            head_q <= '0;
        end else if (fire) begin
            head_q <= tag_next(head_q);
        end
    end

    // Stalled output holds until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_data_o))
        else $error("rob_retire: output changed while stalled");

endmodule

//--- rob_store.sv
// Reorder buffer response storage
module rob_store import rob_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    // Memory responses, any order
    input  logic              rsp_valid_i,
    input  logic [TAG_W-1:0]  rsp_tag_i,
    input  logic [DATA_W-1:0] rsp_data_i,
    // Head entry seen by retire
    input  logic [TAG_W-1:0]  head_tag_i,
    input  logic              retire_i,
    output logic              head_valid_o,
    output logic [DATA_W-1:0] head_data_o
);

    // One data word per tag
    logic [DATA_W-1:0]    data_q [ROB_DEPTH];
    // Entry holds a response not yet retired
    logic [ROB_DEPTH-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            // Clear first so a set on another entry is kept
            if (retire_i) begin
                valid_q[head_tag_i] <= 1'b0;
            end
            if (rsp_valid_i) begin
                valid_q[rsp_tag_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            data_q[rsp_tag_i] <= rsp_data_i;
        end
    end

    // Head lookup, same cycle as the head pointer
    assign head_valid_o = valid_q[head_tag_i];
    assign head_data_o  = data_q[head_tag_i];

    // One response per issued tag, so the slot must still be empty
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> !valid_q[rsp_tag_i])
        else $error("rob_store: second response for tag %0d", rsp_tag_i);

endmodule

//--- rob_top.sv
// Reorder buffer top level
module rob_top import rob_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    // Requests in
    input  logic              req_valid_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    output logic              req_ready_o,
    // Memory requests out
    output logic              mem_req_valid_o,
    output logic [TAG_W-1:0]  mem_req_tag_o,
    output logic [ADDR_W-1:0] mem_req_addr_o,
    // Memory responses in
    input  logic              rsp_valid_i,
    input  logic [TAG_W-1:0]  rsp_tag_i,
    input  logic [DATA_W-1:0] rsp_data_i,
    // Responses out in issue order
    output logic              out_valid_o,
    output logic [DATA_W-1:0] out_data_o,
    input  logic              out_ready_i,
    output logic              busy_o
);

    logic              tag_ret_valid;
    logic [TAG_W-1:0]  tag_ret;
    logic [TAG_W-1:0]  head_tag;
    logic              head_valid;
    logic [DATA_W-1:0] head_data;
    logic              retire;

    rob_issue i_issue (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .req_ready_o     (req_ready_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_tag_o   (mem_req_tag_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .tag_ret_valid_i (tag_ret_valid),
        .tag_ret_i       (tag_ret),
        .busy_o          (busy_o)
    );

    rob_store i_store (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .rsp_valid_i  (rsp_valid_i),
        .rsp_tag_i    (rsp_tag_i),
        .rsp_data_i   (rsp_data_i),
        .head_tag_i   (head_tag),
        .retire_i     (retire),
        .head_valid_o (head_valid),
        .head_data_o  (head_data)
    );

    rob_retire i_retire (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .head_valid_i    (head_valid),
        .head_data_i     (head_data),
        .out_ready_i     (out_ready_i),
        .out_valid_o     (out_valid_o),
        .out_data_o      (out_data_o),
        .head_tag_o      (head_tag),
        .retire_o        (retire),
        .tag_ret_valid_o (tag_ret_valid),
        .tag_ret_o       (tag_ret)
    );

endmodule

//--- tag_queue.sv
// Free-tag FIFO
module tag_queue import rob_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    // Push side, tags coming back from retire
    input  logic [TAG_W-1:0] tag_i,
    input  logic             valid_i,
    output logic             ready_o,
    // Pop side, free tags for new requests
    output logic [TAG_W-1:0] tag_o,
    output logic             valid_o,
    input  logic             ready_i
);

    // Pointers carry one wrap bit above the index
    logic [TAG_W:0]   rd_ptr_d, rd_ptr_q;
    logic [TAG_W:0]   wr_ptr_d, wr_ptr_q;
    logic [TAG_W-1:0] tags_q [ROB_DEPTH];
    logic             reload_q;
    logic             reload;
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;

    // Step a pointer, flipping the wrap bit past the last slot
    function automatic logic [TAG_W:0] ptr_next(input logic [TAG_W:0] ptr);
        logic wrap;
        wrap = (ptr[TAG_W-1:0] == TAG_W'(ROB_DEPTH - 1));
        return {ptr[TAG_W] ^ wrap, tag_next(ptr[TAG_W-1:0])};
    endfunction

    // Refill on flush and in the first cycle out of reset
    assign reload = flush_i || reload_q;

    assign empty = (rd_ptr_q == wr_ptr_q);
    assign full  = (rd_ptr_q[TAG_W] != wr_ptr_q[TAG_W])
                && (rd_ptr_q[TAG_W-1:0] == wr_ptr_q[TAG_W-1:0]);

    assign tag_o = tags_q[rd_ptr_q[TAG_W-1:0]];

    assign pop  = ready_i && valid_o;
    assign push = valid_i && ready_o;

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        if (reload) begin
            // Nothing moves while the array refills
            valid_o  = 1'b0;
            ready_o  = 1'b0;
            // Wrap bits differ, so every tag is free
            rd_ptr_d = {1'b1, {TAG_W{1'b0}}};
            wr_ptr_d = '0;
        end else begin
            valid_o = !empty;
            // A pop in this cycle frees the slot for the push
            ready_o = !full || (SAME_CYCLE_RW && ready_i && !empty);
            if (pop) begin
                rd_ptr_d = ptr_next(rd_ptr_q);
            end
            if (push) begin
                wr_ptr_d = ptr_next(wr_ptr_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Empty until the reload cycle fills it
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            reload_q <= 1'b1;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            reload_q <= 1'b0;
        end
    end

    // Tag array, loaded in order on reload
    always_ff @(posedge clk_i) begin
        if (reload) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                tags_q[i] <= TAG_W'(i);
            end
        end else if (push) begin
            tags_q[wr_ptr_q[TAG_W-1:0]] <= tag_i;
        end
    end

    // Retire never hands back more tags than are out
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(valid_i && !ready_o))
        else $error("tag_queue: push while full");

    // Issue only takes a tag that exists
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(ready_i && !valid_o))
        else $error("tag_queue: pop while empty");

endmodule

//--- tb_rob.sv
// Reorder buffer testbench
module tb_rob import rob_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ROWS    = 27;
    localparam int N_RANDOM  = 40;
    localparam int MAX_DELAY = 30;
    localparam int MAX_STALL = 3;
    // Table rows plus eight rows again after flush and the random pass
    localparam int N_REQ       = N_ROWS + 8 + N_RANDOM;
    localparam int CYCLE_LIMIT = N_REQ * (MAX_DELAY + MAX_STALL + 4) + 50;

    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    logic                      req_valid;
    logic [ADDR_W-1:0]         req_addr;
    logic                      req_ready;
    logic                      mem_req_valid;
    logic [TAG_W-1:0]          mem_req_tag;
    logic [ADDR_W-1:0]         mem_req_addr;
    logic                      rsp_valid;
    logic [TAG_W-1:0]          rsp_tag;
    logic [DATA_W-1:0]         rsp_data;
    logic                      out_valid;
    logic [DATA_W-1:0]         out_data;
    logic                      out_ready;
    logic                      busy;
    logic [ROB_DEPTH-1:0][7:0] delay_tab;

    // Each row holds address, response delay and output stall
    logic [31:0] stim [N_ROWS] = '{
        // Responses come back in reverse order
        32'h1000_0e_00, 32'h1001_0c_02, 32'h1002_0a_00, 32'h1003_08_03,
        32'h1004_06_00, 32'h1005_04_01, 32'h1006_02_00, 32'h1007_00_00,
        // Long delays use up every tag and the rest runs through the wrap
        32'h2000_1e_00, 32'h2001_1c_00, 32'h2002_1a_00, 32'h2003_18_00,
        32'h2004_16_00, 32'h2005_14_00, 32'h2006_12_00, 32'h2007_10_00,
        32'h3000_05_01, 32'h3001_01_00, 32'h3002_03_00, 32'h3003_00_02,
        32'h3004_06_00, 32'h3005_02_00, 32'h3006_04_03, 32'h3007_00_00,
        // Leaves the next tag away from zero before the flush
        32'h3008_01_00, 32'h3009_03_01, 32'h300a_00_00
    };

    string             test_name;
    int                seed;
    int                cycles;
    int                issued;
    int                retired;
    bit                reload_now;
    bit                stalled;
    bit                strobe_due;
    logic [DATA_W-1:0] held_data;
    logic [ADDR_W-1:0] sent_addr;
    logic [TAG_W-1:0]  next_tag;
    logic [TAG_W-1:0]  mem_tag;
    logic [DATA_W-1:0] expect_q [$];
    int                stall_q [$];

    rob_top i_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .flush_i         (flush),
        .req_valid_i     (req_valid),
        .req_addr_i      (req_addr),
        .req_ready_o     (req_ready),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_tag_o   (mem_req_tag),
        .mem_req_addr_o  (mem_req_addr),
        .rsp_valid_i     (rsp_valid),
        .rsp_tag_i       (rsp_tag),
        .rsp_data_i      (rsp_data),
        .out_valid_o     (out_valid),
        .out_data_o      (out_data),
        .out_ready_i     (out_ready),
        .busy_o          (busy)
    );

    tb_rob_mem i_mem (
        .clk_i           (clk),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_tag_i   (mem_req_tag),
        .mem_req_addr_i  (mem_req_addr),
        .delay_i         (delay_tab),
        .rsp_valid_o     (rsp_valid),
        .rsp_tag_o       (rsp_tag),
        .rsp_data_o      (rsp_data)
    );

    always #2 clk = ~clk;

    // Address in the upper half and its inverse in the lower half
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return {addr, ~addr};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     test_name, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic watch_output();
        // A stalled word must still be there unchanged
        if (stalled) begin
            check_value("out_valid_o held", 1'b1, out_valid);
            check_value("out_data_o held", held_data, out_data);
        end
        stalled   = 1'b0;
        out_ready = 1'b0;
        if (out_valid) begin
            if (expect_q.size() == 0) begin
                abort_run("out_valid_o is high with no request outstanding");
            end else if (stall_q[0] > 0) begin
                stall_q[0] = stall_q[0] - 1;
                stalled    = 1'b1;
                held_data  = expect_q[0];
            end else begin
                // Taken at the next edge which frees its tag
                check_value("out_data_o", expect_q.pop_front(), out_data);
                stall_q.delete(0);
                out_ready = 1'b1;
                retired++;
            end
        end
    endtask

    // One clock cycle followed by all per-cycle checks
    task automatic tick();
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
        end
        check_value("req_ready_o", !reload_now && (issued - retired < ROB_DEPTH), req_ready);
        check_value("busy_o", issued != retired, busy);
        // One strobe for each accepted request and none otherwise
        check_value("mem_req_valid_o", strobe_due, mem_req_valid);
        strobe_due = 1'b0;
        // Tags go out in sequence from zero after reset or flush
        if (mem_req_valid) begin
            check_value("mem_req_tag_o", mem_tag, mem_req_tag);
            check_value("mem_req_addr_o", sent_addr, mem_req_addr);
            mem_tag = TAG_W'((mem_tag + 1) % ROB_DEPTH);
        end
        watch_output();
    endtask

    task automatic issue_req(input logic [ADDR_W-1:0] addr, input int delay, input int stall);
        while (!req_ready) begin
            tick();
        end
        req_valid           = 1'b1;
        req_addr            = addr;
        delay_tab[next_tag] = delay[7:0];
        next_tag            = TAG_W'((next_tag + 1) % ROB_DEPTH);
        expect_q.push_back(expected_word(addr));
        stall_q.push_back(stall);
        issued++;
        strobe_due = 1'b1;
        sent_addr  = addr;
        tick();
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (retired != issued) begin
            tick();
        end
        // Last transfer lands and busy_o must drop
        tick();
    endtask

    initial begin
        logic [ADDR_W-1:0] raddr;
        int                rdelay;
        int                rstall;
        seed       = 32'h8258;
        clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        out_ready  = 1'b0;
        delay_tab  = '0;
        reload_now = 1'b1;
        test_name  = "reset";
        repeat (3) tick();
        rst_n      = 1'b1;
        reload_now = 1'b0;

        test_name = "reverse order";
        for (int i = 0; i < 8; i++) begin
            issue_req(stim[i][31:16], stim[i][15:8], stim[i][7:0]);
        end
        drain();

        test_name = "all tags out and wrap";
        for (int i = 8; i < N_ROWS; i++) begin
            issue_req(stim[i][31:16], stim[i][15:8], stim[i][7:0]);
        end
        drain();

        // Idle flush reloads the queue and tags restart at zero
        test_name  = "flush and rerun";
        flush      = 1'b1;
        reload_now = 1'b1;
        tick();
        flush      = 1'b0;
        reload_now = 1'b0;
        next_tag   = '0;
        mem_tag    = '0;
        for (int i = 0; i < 8; i++) begin
            issue_req(stim[i][31:16], stim[i][15:8], stim[i][7:0]);
        end
        drain();

        test_name = "random delays";
        for (int i = 0; i < N_RANDOM; i++) begin
            raddr  = $random(seed);
            rdelay = $unsigned($random(seed)) % 8;
            rstall = $unsigned($random(seed)) % (MAX_STALL + 1);
            issue_req(raddr, rdelay, rstall);
        end
        drain();

        $display("TEST OK");
        $finish;
    end

    initial begin
        cycles     = 0;
        issued     = 0;
        retired    = 0;
        stalled    = 1'b0;
        strobe_due = 1'b0;
        sent_addr  = '0;
        next_tag   = '0;
        mem_tag    = '0;
    end

endmodule

//--- tb_rob_mem.sv
// Out-of-order memory responder
module tb_rob_mem import rob_pkg::*; (
    input  logic                      clk_i,
    input  logic                      mem_req_valid_i,
    input  logic [TAG_W-1:0]          mem_req_tag_i,
    input  logic [ADDR_W-1:0]         mem_req_addr_i,
    // Cycles to hold each request, indexed by tag
    input  logic [ROB_DEPTH-1:0][7:0] delay_i,
    output logic                      rsp_valid_o,
    output logic [TAG_W-1:0]          rsp_tag_o,
    output logic [DATA_W-1:0]         rsp_data_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic              pend [ROB_DEPTH];
    logic [ADDR_W-1:0] addr_q [ROB_DEPTH];
    int                left [ROB_DEPTH];

    initial begin
        rsp_valid_o = 1'b0;
        rsp_tag_o   = '0;
        rsp_data_o  = '0;
        for (int t = 0; t < ROB_DEPTH; t++) begin
            pend[t] = 1'b0;
        end
    end

    // Runs a little after each edge, like the rest of the stimulus
    always begin
        @(posedge clk_i);
        #1;
        rsp_valid_o = 1'b0;
        if (mem_req_valid_i) begin
            pend[mem_req_tag_i]   = 1'b1;
            addr_q[mem_req_tag_i] = mem_req_addr_i;
            left[mem_req_tag_i]   = delay_i[mem_req_tag_i];
        end
        // One response per cycle, due requests wait their turn
        for (int t = 0; t < ROB_DEPTH; t++) begin
            if (pend[t] && left[t] > 0) begin
                left[t]--;
            end else if (pend[t] && !rsp_valid_o) begin
                rsp_valid_o = 1'b1;
                rsp_tag_o   = TAG_W'(t);
                rsp_data_o  = mem_data(addr_q[t]);
                pend[t]     = 1'b0;
            end
        end
    end

endmodule

//--- verilog.f
rob_pkg.sv
tag_queue.sv
rob_issue.sv
rob_store.sv
rob_retire.sv
rob_top.sv
tb_rob_mem.sv
tb_rob.sv
